// File: hw/host_chan_pkg.sv
/*
 * Host channel sharing package
 *
 * Widths, port count and read pipe depth shared by the arbiter,
 * pipeline bridge and response router. Also holds the upstream tag
 * word, which the arbiter builds from a port index and the port's own
 * tag and which the bridge and host treat as a flat value.
 */
package host_chan_pkg;

   // ====================
   // Channel geometry
   // ====================

   // Accelerator ports sharing the single host channel
   localparam int NUM_PORTS       = 4;
   localparam int PORT_BITS       = 2;

   // Word address and data
   localparam int ADDR_WIDTH      = 16;
   localparam int DATA_WIDTH      = 32;

   // Per-port read tag and the widened upstream tag
   localparam int AFU_TAG_BITS    = 6;
   localparam int HOST_TAG_BITS   = PORT_BITS + AFU_TAG_BITS;

   // Register stages between host_readdatavalid and the ports
   localparam int READ_PIPE_DEPTH = 2;

   // ====================
   // Upstream tag word
   // ====================

   // Port index sits in the upper bits, original port tag below it
   typedef struct packed {
      logic [PORT_BITS-1:0]    port;
      logic [AFU_TAG_BITS-1:0] tag;
   } host_tag_split_t;

   // Raw view for the bridge and host, split view for arbiter and router
   typedef union packed {
      logic [HOST_TAG_BITS-1:0] raw;
      host_tag_split_t          split;
   } host_tag_t;

endpackage

// File: hw/host_req_arbiter.sv
/*
 * Host request arbiter
 *
 * Round-robin choice among the accelerator ports for the one host
 * channel. The granted port's request is forwarded combinationally
 * with its port index folded into the upstream tag. The pointer moves
 * past the granted port each time the bridge accepts a request.
 */
module host_req_arbiter
   import host_chan_pkg::*;
(
   input  logic                    Clk_100,
   input  logic                    reset,

   // Accelerator ports
   input  logic                    afu_read        [NUM_PORTS],
   input  logic                    afu_write       [NUM_PORTS],
   input  logic [ADDR_WIDTH-1:0]   afu_address     [NUM_PORTS],
   input  logic [DATA_WIDTH-1:0]   afu_writedata   [NUM_PORTS],
   input  logic [AFU_TAG_BITS-1:0] afu_tag         [NUM_PORTS],
   output logic                    afu_waitrequest [NUM_PORTS],

   // Selected request toward the bridge
   output logic                    sel_read,
   output logic                    sel_write,
   output logic [ADDR_WIDTH-1:0]   sel_address,
   output logic [DATA_WIDTH-1:0]   sel_writedata,
   output host_tag_t               sel_tag,
   input  logic                    bridge_waitrequest
);

   // Search starts here
   logic [PORT_BITS-1:0] rr_ptr;

   logic [NUM_PORTS-1:0] req;
   logic [PORT_BITS-1:0] grant_idx;
   logic                 grant_vld;
   logic                 accept;

   // ====================
   // Grant selection
   // ====================

   always_comb
   begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         req[i] = afu_read[i] | afu_write[i];
      end
   end

   // First requesting port at or after the pointer, wrapping around
   always_comb
   begin : pick
      logic [PORT_BITS-1:0] cand;

      grant_vld = 1'b0;
      grant_idx = rr_ptr;
      for (int k = 0; k < NUM_PORTS; k++)
      begin
         cand = rr_ptr + PORT_BITS'(k);
         if (!grant_vld && req[cand])
         begin
            grant_vld = 1'b1;
            grant_idx = cand;
         end
      end
   end

   // ====================
   // Request mux
   // ====================

   always_comb
   begin
      sel_read             = grant_vld & afu_read[grant_idx];
      sel_write            = grant_vld & afu_write[grant_idx];
      sel_address          = afu_address[grant_idx];
      sel_writedata        = afu_writedata[grant_idx];
      sel_tag.split.port   = grant_idx;
      sel_tag.split.tag    = afu_tag[grant_idx];
   end

   // Only the granted port sees waitrequest low, and only when the bridge has room
   always_comb
   begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         afu_waitrequest[i] = bridge_waitrequest | ~grant_vld |
                              (grant_idx != PORT_BITS'(i));
      end
   end

   assign accept = grant_vld & ~bridge_waitrequest;

   // ====================
   // Round-robin pointer
   // ====================

   always_ff @(posedge Clk_100)
   begin
      if (reset)
      begin
         rr_ptr <= '0;
      end
      else if (accept)
      begin
         // Wraps naturally since NUM_PORTS is a power of two
         rr_ptr <= grant_idx + 1'b1;
      end
   end

endmodule

// File: hw/host_rsp_router.sv
/*
 * Host response router
 *
 * Splits the tag of each returned read into port index and original
 * port tag, and raises readdatavalid on the owning port only. Purely
 * combinational from the last read pipe stage of the bridge.
 */
module host_rsp_router
   import host_chan_pkg::*;
(
   // Last stage of the bridge read pipe
   input  logic                    pipe_readdatavalid,
   input  logic [DATA_WIDTH-1:0]   pipe_readdata,
   input  host_tag_t               pipe_tag,

   // Per-port read responses
   output logic                    afu_readdatavalid [NUM_PORTS],
   output logic [DATA_WIDTH-1:0]   afu_readdata      [NUM_PORTS],
   output logic [AFU_TAG_BITS-1:0] afu_rsp_tag       [NUM_PORTS]
);

   logic [PORT_BITS-1:0]    rsp_port;
   logic [AFU_TAG_BITS-1:0] rsp_tag;

   // ====================
   // Tag decode
   // ====================

   // The arbiter packed the port index above the original tag
   assign rsp_port = pipe_tag.split.port;
   assign rsp_tag  = pipe_tag.split.tag;

   // ====================
   // Per-port delivery
   // ====================

   always_comb
   begin
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         // One-hot valid, data and tag fan out to every port
         afu_readdatavalid[i] = pipe_readdatavalid &
                                (rsp_port == PORT_BITS'(i));
         afu_readdata[i]      = pipe_readdata;
         afu_rsp_tag[i]       = rsp_tag;
      end
   end

endmodule

// File: hw/host_pipe_bridge.sv
/*
 * Host pipeline bridge
 *
 * Registers the request path through a two-entry skid buffer with a
 * registered waitrequest toward the arbiter, and carries host read
 * responses through a fixed READ_PIPE_DEPTH register pipeline.
 */
module host_pipe_bridge
   import host_chan_pkg::*;
(
   input  logic                     Clk_100,
   input  logic                     reset,

   // Request from the arbiter
   input  logic                     sel_read,
   input  logic                     sel_write,
   input  logic [ADDR_WIDTH-1:0]    sel_address,
   input  logic [DATA_WIDTH-1:0]    sel_writedata,
   input  host_tag_t                sel_tag,
   output logic                     bridge_waitrequest,

   // Host channel
   output logic                     host_read,
   output logic                     host_write,
   output logic [ADDR_WIDTH-1:0]    host_address,
   output logic [DATA_WIDTH-1:0]    host_writedata,
   output logic [HOST_TAG_BITS-1:0] host_tag,
   input  logic                     host_waitrequest,
   input  logic                     host_readdatavalid,
   input  logic [DATA_WIDTH-1:0]    host_readdata,
   input  logic [HOST_TAG_BITS-1:0] host_rsp_tag,

   // Read responses toward the router
   output logic                     pipe_readdatavalid,
   output logic [DATA_WIDTH-1:0]    pipe_readdata,
   output host_tag_t                pipe_tag
);

   // ====================
   // Request skid buffer
   // ====================

   // Two entries, payload only
   logic                  req_rd_q   [2];
   logic                  req_wr_q   [2];
   logic [ADDR_WIDTH-1:0] req_addr_q [2];
   logic [DATA_WIDTH-1:0] req_data_q [2];
   host_tag_t             req_tag_q  [2];

   logic                  wr_ptr;
   logic                  rd_ptr;
   logic [1:0]            count;
   logic [1:0]            count_next;
   logic                  push;
   logic                  pop;

   assign push       = (sel_read | sel_write) & ~bridge_waitrequest;
   assign pop        = (count != 2'd0) & ~host_waitrequest;
   assign count_next = count + {1'b0, push} - {1'b0, pop};

   always_ff @(posedge Clk_100)
   begin
      if (reset)
      begin
         count              <= '0;
         wr_ptr             <= 1'b0;
         rd_ptr             <= 1'b0;
         // Held off for the first cycle out of reset
         bridge_waitrequest <= 1'b1;
      end
      else
      begin
         count              <= count_next;
         bridge_waitrequest <= (count_next == 2'd2);
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
      end
   end

   always_ff @(posedge Clk_100)
   begin
      if (push)
      begin
         req_rd_q[wr_ptr]   <= sel_read;
         req_wr_q[wr_ptr]   <= sel_write;
         req_addr_q[wr_ptr] <= sel_address;
         req_data_q[wr_ptr] <= sel_writedata;
         req_tag_q[wr_ptr]  <= sel_tag;
      end
   end

   // Head entry stays put until the host drops waitrequest
   assign host_read      = (count != 2'd0) & req_rd_q[rd_ptr];
   assign host_write     = (count != 2'd0) & req_wr_q[rd_ptr];
   assign host_address   = req_addr_q[rd_ptr];
   assign host_writedata = req_data_q[rd_ptr];
   assign host_tag       = req_tag_q[rd_ptr].raw;

   // ====================
   // Read data pipe
   // ====================

   logic                  rsp_vld_q  [READ_PIPE_DEPTH];
   logic [DATA_WIDTH-1:0] rsp_data_q [READ_PIPE_DEPTH];
   host_tag_t             rsp_tag_q  [READ_PIPE_DEPTH];

   always_ff @(posedge Clk_100)
   begin
      if (reset)
      begin
         for (int s = 0; s < READ_PIPE_DEPTH; s++)
            rsp_vld_q[s] <= 1'b0;
      end
      else
      begin
         rsp_vld_q[0] <= host_readdatavalid;
         for (int s = 1; s < READ_PIPE_DEPTH; s++)
            rsp_vld_q[s] <= rsp_vld_q[s-1];
      end
   end

   always_ff @(posedge Clk_100)
   begin
      rsp_data_q[0]    <= host_readdata;
      rsp_tag_q[0].raw <= host_rsp_tag;
      for (int s = 1; s < READ_PIPE_DEPTH; s++)
      begin
         rsp_data_q[s] <= rsp_data_q[s-1];
         rsp_tag_q[s]  <= rsp_tag_q[s-1];
      end
   end

   assign pipe_readdatavalid = rsp_vld_q[READ_PIPE_DEPTH-1];
   assign pipe_readdata      = rsp_data_q[READ_PIPE_DEPTH-1];
   assign pipe_tag           = rsp_tag_q[READ_PIPE_DEPTH-1];

endmodule

// File: hw/host_chan_top.sv
/*
 * Host channel sharing top level
 *
 * Four accelerator ports share one host memory channel: a round-robin
 * arbiter feeds the pipeline bridge, and read responses coming back
 * through the bridge are routed to their port by tag.
 */
module host_chan_top
   import host_chan_pkg::*;
(
   input  logic                     Clk_100,
   input  logic                     reset,

   // Accelerator ports
   input  logic                     afu_read          [NUM_PORTS],
   input  logic                     afu_write         [NUM_PORTS],
   input  logic [ADDR_WIDTH-1:0]    afu_address       [NUM_PORTS],
   input  logic [DATA_WIDTH-1:0]    afu_writedata     [NUM_PORTS],
   input  logic [AFU_TAG_BITS-1:0]  afu_tag           [NUM_PORTS],
   output logic                     afu_waitrequest   [NUM_PORTS],
   output logic                     afu_readdatavalid [NUM_PORTS],
   output logic [DATA_WIDTH-1:0]    afu_readdata      [NUM_PORTS],
   output logic [AFU_TAG_BITS-1:0]  afu_rsp_tag       [NUM_PORTS],

   // Host channel
   output logic                     host_read,
   output logic                     host_write,
   output logic [ADDR_WIDTH-1:0]    host_address,
   output logic [DATA_WIDTH-1:0]    host_writedata,
   output logic [HOST_TAG_BITS-1:0] host_tag,
   input  logic                     host_waitrequest,
   input  logic                     host_readdatavalid,
   input  logic [DATA_WIDTH-1:0]    host_readdata,
   input  logic [HOST_TAG_BITS-1:0] host_rsp_tag
);

   // Arbiter to bridge
   logic                  sel_read;
   logic                  sel_write;
   logic [ADDR_WIDTH-1:0] sel_address;
   logic [DATA_WIDTH-1:0] sel_writedata;
   host_tag_t             sel_tag;
   logic                  bridge_waitrequest;

   // Bridge to router
   logic                  pipe_readdatavalid;
   logic [DATA_WIDTH-1:0] pipe_readdata;
   host_tag_t             pipe_tag;

   host_req_arbiter u_arbiter (
      .Clk_100            (Clk_100),
      .reset              (reset),
      .afu_read           (afu_read),
      .afu_write          (afu_write),
      .afu_address        (afu_address),
      .afu_writedata      (afu_writedata),
      .afu_tag            (afu_tag),
      .afu_waitrequest    (afu_waitrequest),
      .sel_read           (sel_read),
      .sel_write          (sel_write),
      .sel_address        (sel_address),
      .sel_writedata      (sel_writedata),
      .sel_tag            (sel_tag),
      .bridge_waitrequest (bridge_waitrequest)
   );

   host_pipe_bridge u_bridge (
      .Clk_100            (Clk_100),
      .reset              (reset),
      .sel_read           (sel_read),
      .sel_write          (sel_write),
      .sel_address        (sel_address),
      .sel_writedata      (sel_writedata),
      .sel_tag            (sel_tag),
      .bridge_waitrequest (bridge_waitrequest),
      .host_read          (host_read),
      .host_write         (host_write),
      .host_address       (host_address),
      .host_writedata     (host_writedata),
      .host_tag           (host_tag),
      .host_waitrequest   (host_waitrequest),
      .host_readdatavalid (host_readdatavalid),
      .host_readdata      (host_readdata),
      .host_rsp_tag       (host_rsp_tag),
      .pipe_readdatavalid (pipe_readdatavalid),
      .pipe_readdata      (pipe_readdata),
      .pipe_tag           (pipe_tag)
   );

   host_rsp_router u_router (
      .pipe_readdatavalid (pipe_readdatavalid),
      .pipe_readdata      (pipe_readdata),
      .pipe_tag           (pipe_tag),
      .afu_readdatavalid  (afu_readdatavalid),
      .afu_readdata       (afu_readdata),
      .afu_rsp_tag        (afu_rsp_tag)
   );

endmodule

// File: tb/host_chan_props.sv
/*
 * Host channel handshake properties
 *
 * Bound into the top level. Covers host request stability under
 * waitrequest, one-hot port responses, quiet responses in reset and
 * the fixed read latency through the bridge.
 */
module host_chan_props
   import host_chan_pkg::*;
(
   input  logic                     Clk_100,
   input  logic                     reset,
   input  logic                     host_read,
   input  logic                     host_write,
   input  logic [ADDR_WIDTH-1:0]    host_address,
   input  logic [DATA_WIDTH-1:0]    host_writedata,
   input  logic [HOST_TAG_BITS-1:0] host_tag,
   input  logic                     host_waitrequest,
   input  logic                     host_readdatavalid,
   input  logic                     afu_readdatavalid [NUM_PORTS]
);

   logic [NUM_PORTS-1:0] rdv_vec;

   always_comb
   begin
      for (int i = 0; i < NUM_PORTS; i++)
         rdv_vec[i] = afu_readdatavalid[i];
   end

   // Stalled host request holds every field
   host_req_stable: assert property (@(posedge Clk_100) disable iff (reset)
      (host_read | host_write) & host_waitrequest |=>
         $stable({host_read, host_write, host_address, host_writedata, host_tag}))
      else $error("host request changed while host_waitrequest was high");

   rsp_onehot: assert property (@(posedge Clk_100) $onehot0(rdv_vec))
      else $error("more than one port saw readdatavalid in the same cycle");

   rsp_quiet_in_reset: assert property (@(posedge Clk_100) $past(reset) |-> rdv_vec == '0)
      else $error("readdatavalid raised while in reset");

   // Two register stages between host and port
   read_latency: assert property (@(posedge Clk_100) disable iff (reset)
      host_readdatavalid |-> ##2 (rdv_vec != '0))
      else $error("host read response did not reach a port two cycles later");

endmodule

bind host_chan_top host_chan_props u_props (
   .Clk_100            (Clk_100),
   .reset              (reset),
   .host_read          (host_read),
   .host_write         (host_write),
   .host_address       (host_address),
   .host_writedata     (host_writedata),
   .host_tag           (host_tag),
   .host_waitrequest   (host_waitrequest),
   .host_readdatavalid (host_readdatavalid),
   .afu_readdatavalid  (afu_readdatavalid)
);

// File: tb/host_chan_tb.sv
/*
 * Host channel sharing testbench
 *
 * Drives the four accelerator ports from a vector file, models the host
 * memory with random waitrequest and read delay, and checks read data,
 * response routing, round-robin order and a final readback of every
 * written address.
 */
module host_chan_tb
   import host_chan_pkg::*;
();

   localparam int CLK_HALF        = 4;
   localparam int VEC_COUNT       = 40;
   localparam int VEC_FIELDS      = 5;
   localparam int MAX_OPS         = 64;
   localparam int MAX_DELAY       = 6;
   localparam int WATCHDOG_CYCLES = VEC_COUNT * MAX_DELAY * 4;

   logic                     Clk_100;
   logic                     reset;
   logic                     afu_read          [NUM_PORTS];
   logic                     afu_write         [NUM_PORTS];
   logic [ADDR_WIDTH-1:0]    afu_address       [NUM_PORTS];
   logic [DATA_WIDTH-1:0]    afu_writedata     [NUM_PORTS];
   logic [AFU_TAG_BITS-1:0]  afu_tag           [NUM_PORTS];
   logic                     afu_waitrequest   [NUM_PORTS];
   logic                     afu_readdatavalid [NUM_PORTS];
   logic [DATA_WIDTH-1:0]    afu_readdata      [NUM_PORTS];
   logic [AFU_TAG_BITS-1:0]  afu_rsp_tag       [NUM_PORTS];
   logic                     host_read;
   logic                     host_write;
   logic [ADDR_WIDTH-1:0]    host_address;
   logic [DATA_WIDTH-1:0]    host_writedata;
   logic [HOST_TAG_BITS-1:0] host_tag;
   logic                     host_waitrequest;
   logic                     host_readdatavalid;
   logic [DATA_WIDTH-1:0]    host_readdata;
   logic [HOST_TAG_BITS-1:0] host_rsp_tag;

   // Operation table indexed by tag
   logic [31:0]           vec_mem    [VEC_COUNT*VEC_FIELDS];
   logic                  op_write   [MAX_OPS];
   int                    op_port    [MAX_OPS];
   logic [ADDR_WIDTH-1:0] op_addr    [MAX_OPS];
   logic [DATA_WIDTH-1:0] op_data    [MAX_OPS];
   logic [DATA_WIDTH-1:0] op_exp     [MAX_OPS];
   bit                    op_pending [MAX_OPS];
   int                    op_count;
   int                    cur_op     [NUM_PORTS];
   int                    next_scan  [NUM_PORTS];

   // Host memory model and the record of port writes
   logic [DATA_WIDTH-1:0] host_mem [1<<ADDR_WIDTH];
   logic [DATA_WIDTH-1:0] shadow   [1<<ADDR_WIDTH];
   bit                    written  [1<<ADDR_WIDTH];
   int                    pend_due[$];
   logic [DATA_WIDTH-1:0] pend_data[$];
   logic [HOST_TAG_BITS-1:0] pend_tag[$];
   int                    order_q[$];
   logic [31:0]           rng_state;

   int cycle;
   int accepted_ops;
   int outstanding;
   int last_port;
   int rr_checks;
   int port_writes;
   int port_reads;
   int host_writes;
   int host_reads;
   int mismatch_errors;
   int other_errors;

   host_chan_top u_dut (.*);

   initial
   begin
      Clk_100 = 1'b0;
      forever #CLK_HALF Clk_100 = ~Clk_100;
   end

   // ====================
   // Helpers
   // ====================

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int unsigned rand_below(input int unsigned n);
      rng_state = xorshift32(rng_state);
      return rng_state % n;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp)
      else
      begin
         mismatch_errors++;
         $display("Mismatch %s: expected %h, actual %h", name, exp, got);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond)
      else
      begin
         other_errors++;
         $display("Error: %s", what);
      end
   endtask

   // Random stalls and in-order answers once a read's delay has run out
   task automatic drive_host();
      host_waitrequest   = (rand_below(4) == 0);
      host_readdatavalid = 1'b0;
      if (pend_due.size() > 0 && pend_due[0] <= cycle)
      begin
         host_readdatavalid = 1'b1;
         host_readdata      = pend_data.pop_front();
         host_rsp_tag       = pend_tag.pop_front();
         void'(pend_due.pop_front());
      end
   endtask

   task automatic drive_ports(input int last);
      int idx;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         if (cur_op[p] < 0)
         begin
            idx = next_scan[p];
            while (idx <= last && op_port[idx] != p)
               idx++;
            next_scan[p] = (idx <= last) ? idx + 1 : idx;
            cur_op[p]    = (idx <= last) ? idx : -1;
         end
         if (cur_op[p] >= 0)
         begin
            afu_read[p]      = ~op_write[cur_op[p]];
            afu_write[p]     = op_write[cur_op[p]];
            afu_address[p]   = op_addr[cur_op[p]];
            afu_writedata[p] = op_data[cur_op[p]];
            afu_tag[p]       = AFU_TAG_BITS'(cur_op[p]);
         end
         else
         begin
            afu_read[p]  = 1'b0;
            afu_write[p] = 1'b0;
         end
      end
   endtask

   task automatic sample_ports();
      logic all_busy;
      int   idx;
      all_busy = 1'b1;
      for (int p = 0; p < NUM_PORTS; p++)
         all_busy &= afu_read[p] | afu_write[p];
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         if ((afu_read[p] || afu_write[p]) && !afu_waitrequest[p])
         begin
            idx = cur_op[p];
            if (op_write[idx])
            begin
               shadow[op_addr[idx]]  = op_data[idx];
               written[op_addr[idx]] = 1'b1;
               port_writes++;
            end
            else
            begin
               op_pending[idx] = 1'b1;
               outstanding++;
               port_reads++;
            end
            order_q.push_back(all_busy ? p + NUM_PORTS : p);
            accepted_ops++;
            cur_op[p] = -1;
         end
      end
   endtask

   task automatic sample_host();
      int               entry;
      logic [PORT_BITS-1:0] hp;
      if ((host_read || host_write) && !host_waitrequest)
      begin
         // Port index rides in the upper bits of the host tag
         hp = host_tag[HOST_TAG_BITS-1 -: PORT_BITS];
         check_true(order_q.size() > 0, "host request without a matching port request");
         entry = (order_q.size() > 0) ? order_q.pop_front() : 0;
         check_value("request order port", DATA_WIDTH'(entry % NUM_PORTS), DATA_WIDTH'(hp));
         if (entry >= NUM_PORTS && last_port >= 0)
         begin
            check_value("round-robin port", DATA_WIDTH'((last_port + 1) % NUM_PORTS),
                        DATA_WIDTH'(hp));
            rr_checks++;
         end
         last_port = int'(hp);
         if (host_write)
         begin
            host_mem[host_address] = host_writedata;
            host_writes++;
         end
         else
         begin
            pend_due.push_back(cycle + 1 + int'(rand_below(MAX_DELAY)));
            pend_data.push_back(host_mem[host_address]);
            pend_tag.push_back(host_tag);
            host_reads++;
         end
      end
   endtask

   task automatic check_responses();
      int t;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         if (afu_readdatavalid[p])
         begin
            t = int'(afu_rsp_tag[p]);
            check_true(op_pending[t] && op_port[t] == p,
                       $sformatf("port %0d got a response with tag %0d it did not issue", p, t));
            check_value($sformatf("read data op %0d", t), op_exp[t], afu_readdata[p]);
            if (op_pending[t])
               outstanding--;
            op_pending[t] = 1'b0;
         end
      end
   endtask

   // Drive on the falling edge and sample once everything has settled
   task automatic step_cycle(input int last);
      @(negedge Clk_100);
      cycle++;
      drive_host();
      drive_ports(last);
      #1;
      sample_ports();
      sample_host();
      check_responses();
   endtask

   task automatic run_ops(input int first, input int last);
      int target;
      target = accepted_ops + (last - first + 1);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         cur_op[p]    = -1;
         next_scan[p] = first;
      end
      while (accepted_ops < target || outstanding > 0)
         step_cycle(last);
   endtask

   // ====================
   // Main sequence
   // ====================

   initial
   begin
      reset              = 1'b1;
      host_waitrequest   = 1'b0;
      host_readdatavalid = 1'b0;
      host_readdata      = '0;
      host_rsp_tag       = '0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         afu_read[p]      = 1'b0;
         afu_write[p]     = 1'b0;
         afu_address[p]   = '0;
         afu_writedata[p] = '0;
         afu_tag[p]       = '0;
      end
      rng_state       = 32'd78;
      cycle           = 0;
      accepted_ops    = 0;
      outstanding     = 0;
      rr_checks       = 0;
      port_writes     = 0;
      port_reads      = 0;
      host_writes     = 0;
      host_reads      = 0;
      mismatch_errors = 0;
      other_errors    = 0;
      last_port       = -1;
      for (int a = 0; a < (1 << ADDR_WIDTH); a++)
      begin
         host_mem[a] = {~ADDR_WIDTH'(a), ADDR_WIDTH'(a)};
         written[a]  = 1'b0;
      end

      $readmemh("tb/host_chan_vectors.txt", vec_mem);
      for (int i = 0; i < VEC_COUNT; i++)
      begin
         op_write[i]   = vec_mem[i*VEC_FIELDS][0];
         op_port[i]    = int'(vec_mem[i*VEC_FIELDS+1]);
         op_addr[i]    = vec_mem[i*VEC_FIELDS+2][ADDR_WIDTH-1:0];
         op_data[i]    = vec_mem[i*VEC_FIELDS+3];
         op_exp[i]     = vec_mem[i*VEC_FIELDS+4];
         op_pending[i] = 1'b0;
      end
      op_count = VEC_COUNT;

      repeat (4) @(negedge Clk_100);
      reset = 1'b0;

      // Quiet host side and ports until the first vector
      repeat (3)
      begin
         @(negedge Clk_100);
         #1;
         check_true(!host_read && !host_write, "host request active after reset");
         for (int p = 0; p < NUM_PORTS; p++)
            check_true(!afu_readdatavalid[p], "readdatavalid active after reset");
      end

      run_ops(0, VEC_COUNT - 1);

      // Read back every written address from its owning port
      for (int a = 0; a < (1 << ADDR_WIDTH); a++)
      begin
         if (written[a] && op_count < MAX_OPS)
         begin
            op_write[op_count]   = 1'b0;
            op_port[op_count]    = a >> 12;
            op_addr[op_count]    = ADDR_WIDTH'(a);
            op_data[op_count]    = '0;
            op_exp[op_count]     = shadow[a];
            op_pending[op_count] = 1'b0;
            op_count++;
         end
      end
      run_ops(VEC_COUNT, op_count - 1);

      check_value("host write count", DATA_WIDTH'(port_writes), DATA_WIDTH'(host_writes));
      check_value("host read count", DATA_WIDTH'(port_reads), DATA_WIDTH'(host_reads));
      check_true(rr_checks > 0, "round-robin order never seen with all ports busy");

      $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      if (mismatch_errors + other_errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge Clk_100);
      $display("Timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: tb/host_chan_vectors.txt
// Columns: op (1 write, 0 read), port, word address, write data, expected read data
// The first data line carries tag 0, each following line the next tag
1 0 0010 A0000010 00000000
1 1 1020 B0001020 00000000
1 2 2030 C0002030 00000000
1 3 3040 D0003040 00000000
1 0 0011 A0000011 00000000
1 1 1021 B0001021 00000000
1 2 2031 C0002031 00000000
1 3 3041 D0003041 00000000
0 0 0010 00000000 A0000010
0 1 1020 00000000 B0001020
0 2 2030 00000000 C0002030
0 3 3040 00000000 D0003040
1 0 0012 A0000012 00000000
1 1 1022 B0001022 00000000
1 2 2032 C0002032 00000000
1 3 3042 D0003042 00000000
0 0 0011 00000000 A0000011
0 1 1021 00000000 B0001021
0 2 2031 00000000 C0002031
0 3 3041 00000000 D0003041
1 0 0010 A00001F0 00000000
1 1 1020 B00012F0 00000000
1 2 2030 C00023F0 00000000
1 3 3040 D00034F0 00000000
0 0 0010 00000000 A00001F0
0 1 1020 00000000 B00012F0
0 2 2030 00000000 C00023F0
0 3 3040 00000000 D00034F0
0 0 0012 00000000 A0000012
0 1 1022 00000000 B0001022
0 2 2032 00000000 C0002032
0 3 3042 00000000 D0003042
1 0 0013 A0000013 00000000
1 1 1023 B0001023 00000000
1 2 2033 C0002033 00000000
1 3 3043 D0003043 00000000
0 0 0013 00000000 A0000013
0 1 1023 00000000 B0001023
0 2 2033 00000000 C0002033
0 3 3043 00000000 D0003043

// File: host_chan.f
hw/host_chan_pkg.sv
hw/host_req_arbiter.sv
hw/host_rsp_router.sv
hw/host_pipe_bridge.sv
hw/host_chan_top.sv
tb/host_chan_props.sv
tb/host_chan_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the host channel testbench with Verilator.
# The run fails when the log holds the fail message or no result at all.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module host_chan_tb -f host_chan.f -o host_chan_sim \
   > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/host_chan_sim > "$LOG" 2>&1

grep -q "Simulation finished: FAIL" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "Simulation finished: PASS" "$LOG" || { echo "No result found in $LOG"; exit 1; }
echo "Simulation passed"
exit 0
